/* pu_pkg.sv */
package pu_pkg;

  // Data path widths
  localparam int PU_DATA_W = 32;
  localparam int PU_OPND_W = PU_DATA_W / 2;

  // Attribute bus is PU_ATTR_W+1 bits wide
  localparam int PU_ATTR_W      = 4;
  localparam int PU_INVALID_BIT = 0;

  // Array size
  localparam int PU_COUNT = 4;
  localparam int PU_IDX_W = 2;

  // Command op codes
  localparam int PU_OP_W = 2;
  localparam logic [PU_OP_W-1:0] OP_WR_A = 2'd0; // Write operand A, sel high
  localparam logic [PU_OP_W-1:0] OP_WR_B = 2'd1; // Write operand B, sel low, triggers product
  localparam logic [PU_OP_W-1:0] OP_READ = 2'd2; // One-cycle output enable

endpackage

/* pu_mult.sv */
`timescale 1ns/10ps

module pu_mult import pu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 signal_wr,
  input  logic                 signal_sel,
  input  logic [PU_DATA_W-1:0] data_in,
  input  logic [PU_ATTR_W:0]   attr_in,
  input  logic                 signal_oe,
  output logic [PU_DATA_W-1:0] data_out,
  output logic [PU_ATTR_W:0]   attr_out
);

  logic [PU_DATA_W-1:0] opnd_a;
  logic [PU_DATA_W-1:0] opnd_b;
  logic                 opnd_a_inv; // Invalid flag carried in with the operand
  logic                 opnd_b_inv;

  logic                 a_out_of_range;
  logic                 b_out_of_range;
  logic                 invalid_value;
  logic [PU_DATA_W-1:0] product;

  logic                 sel_q;
  logic                 trigger;

  logic [PU_DATA_W-1:0] result_data;
  logic                 result_invalid;

  // Operand latch, sel picks the slot
  always_ff @(posedge clk) begin
    if (signal_wr) begin
      if (signal_sel) begin
        opnd_a     <= data_in;
        opnd_a_inv <= attr_in[PU_INVALID_BIT];
      end else begin
        opnd_b     <= data_in;
        opnd_b_inv <= attr_in[PU_INVALID_BIT];
      end
    end
  end

  // Upper half plus the operand sign bit must be a pure sign extension
  assign a_out_of_range = !((~|opnd_a[PU_DATA_W-1:PU_OPND_W-1]) ||
                            (&opnd_a[PU_DATA_W-1:PU_OPND_W-1]));
  assign b_out_of_range = !((~|opnd_b[PU_DATA_W-1:PU_OPND_W-1]) ||
                            (&opnd_b[PU_DATA_W-1:PU_OPND_W-1]));

  assign invalid_value = a_out_of_range || b_out_of_range || opnd_a_inv || opnd_b_inv;

  // Signed 16x16, sign extended to the full word before the multiply
  assign product = $signed(opnd_a[PU_OPND_W-1:0]) * $signed(opnd_b[PU_OPND_W-1:0]);

  // Falling edge of sel marks a completed A then B pair
  always_ff @(posedge clk) begin
    if (rst) begin
      sel_q   <= 1'b0;
      trigger <= 1'b0;
    end else begin
      sel_q   <= signal_sel;
      trigger <= sel_q && !signal_sel;
    end
  end

  // Result holds until the next product
  always_ff @(posedge clk) begin
    if (rst) begin
      result_data    <= '0;
      result_invalid <= 1'b0;
    end else if (trigger) begin
      result_data    <= product;
      result_invalid <= invalid_value;
    end
  end

  always_comb begin
    attr_out = '0;
    data_out = '0;
    if (signal_oe) begin
      data_out                 = result_data;
      attr_out[PU_INVALID_BIT] = result_invalid;
    end
  end

endmodule

/* pu_dispatch.sv */
`timescale 1ns/10ps

module pu_dispatch import pu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 cmd_valid,
  input  logic [PU_IDX_W-1:0]  cmd_pu,
  input  logic [PU_OP_W-1:0]   cmd_op,
  input  logic [PU_DATA_W-1:0] cmd_data,
  input  logic [PU_ATTR_W:0]   cmd_attr,
  output logic [PU_COUNT-1:0]  pu_wr,
  output logic [PU_COUNT-1:0]  pu_sel,
  output logic [PU_COUNT-1:0]  pu_oe,
  output logic [PU_DATA_W-1:0] pu_data,
  output logic [PU_ATTR_W:0]   pu_attr
);

  logic is_wr_a;
  logic is_wr_b;
  logic is_read;

  assign is_wr_a = cmd_valid && (cmd_op == OP_WR_A);
  assign is_wr_b = cmd_valid && (cmd_op == OP_WR_B);
  assign is_read = cmd_valid && (cmd_op == OP_READ); // Unused op codes are dropped

  // Strobes last one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      pu_wr <= '0;
      pu_oe <= '0;
    end else begin
      pu_wr <= '0;
      pu_oe <= '0;
      if (is_wr_a || is_wr_b) begin
        pu_wr[cmd_pu] <= 1'b1;
      end
      if (is_read) begin
        pu_oe[cmd_pu] <= 1'b1;
      end
    end
  end

  // Sel is a level, only writes move it
  always_ff @(posedge clk) begin
    if (rst) begin
      pu_sel <= '0;
    end else if (is_wr_a || is_wr_b) begin
      pu_sel[cmd_pu] <= is_wr_a;
    end
  end

  // Shared word, aligned with the strobes
  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      pu_data <= cmd_data;
      pu_attr <= cmd_attr;
    end
  end

endmodule

/* pu_collect.sv */
`timescale 1ns/10ps

module pu_collect import pu_pkg::*; (
  input  logic                               clk,
  input  logic                               rst,
  input  logic [PU_COUNT-1:0]                pu_oe,
  input  logic [PU_COUNT-1:0][PU_DATA_W-1:0] unit_data,
  input  logic [PU_COUNT-1:0][PU_ATTR_W:0]   unit_attr,
  output logic                               rsp_valid,
  output logic [PU_IDX_W-1:0]                rsp_pu,
  output logic [PU_DATA_W-1:0]               rsp_data,
  output logic [PU_ATTR_W:0]                 rsp_attr
);

  logic [PU_DATA_W-1:0] merged_data;
  logic [PU_ATTR_W:0]   merged_attr;
  logic [PU_IDX_W-1:0]  merged_idx;

  // Disabled units drive zero, so a plain OR merges them
  always_comb begin
    merged_data = '0;
    merged_attr = '0;
    merged_idx  = '0;
    for (int i = 0; i < PU_COUNT; i++) begin
      merged_data = merged_data | unit_data[i];
      merged_attr = merged_attr | unit_attr[i];
      if (pu_oe[i]) begin
        merged_idx = merged_idx | PU_IDX_W'(i); // One-hot to index
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= |pu_oe;
    end
  end

  always_ff @(posedge clk) begin
    rsp_pu   <= merged_idx;
    rsp_data <= merged_data;
    rsp_attr <= merged_attr;
  end

endmodule

/* pu_array_top.sv */
`timescale 1ns/10ps

module pu_array_top import pu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 cmd_valid,
  input  logic [PU_IDX_W-1:0]  cmd_pu,
  input  logic [PU_OP_W-1:0]   cmd_op,
  input  logic [PU_DATA_W-1:0] cmd_data,
  input  logic [PU_ATTR_W:0]   cmd_attr,
  output logic                 rsp_valid,
  output logic [PU_IDX_W-1:0]  rsp_pu,
  output logic [PU_DATA_W-1:0] rsp_data,
  output logic [PU_ATTR_W:0]   rsp_attr
);

  logic [PU_COUNT-1:0]                pu_wr;
  logic [PU_COUNT-1:0]                pu_sel;
  logic [PU_COUNT-1:0]                pu_oe;
  logic [PU_DATA_W-1:0]               pu_data;
  logic [PU_ATTR_W:0]                 pu_attr;
  logic [PU_COUNT-1:0][PU_DATA_W-1:0] unit_data;
  logic [PU_COUNT-1:0][PU_ATTR_W:0]   unit_attr;

  pu_dispatch i_pu_dispatch (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd_pu    (cmd_pu),
    .cmd_op    (cmd_op),
    .cmd_data  (cmd_data),
    .cmd_attr  (cmd_attr),
    .pu_wr     (pu_wr),
    .pu_sel    (pu_sel),
    .pu_oe     (pu_oe),
    .pu_data   (pu_data),
    .pu_attr   (pu_attr)
  );

  for (genvar i = 0; i < PU_COUNT; i++) begin : g_pu
    pu_mult i_pu_mult (
      .clk        (clk),
      .rst        (rst),
      .signal_wr  (pu_wr[i]),
      .signal_sel (pu_sel[i]),
      .data_in    (pu_data),   // Shared by all units
      .attr_in    (pu_attr),
      .signal_oe  (pu_oe[i]),
      .data_out   (unit_data[i]),
      .attr_out   (unit_attr[i])
    );
  end

  pu_collect i_pu_collect (
    .clk       (clk),
    .rst       (rst),
    .pu_oe     (pu_oe),
    .unit_data (unit_data),
    .unit_attr (unit_attr),
    .rsp_valid (rsp_valid),
    .rsp_pu    (rsp_pu),
    .rsp_data  (rsp_data),
    .rsp_attr  (rsp_attr)
  );

endmodule

/* pu_array_assertions.sv */
`timescale 1ns/10ps

module pu_array_assertions import pu_pkg::*; (
  input logic                clk,
  input logic                rst,
  input logic                cmd_valid,
  input logic [PU_OP_W-1:0]  cmd_op,
  input logic [PU_IDX_W-1:0] cmd_pu,
  input logic                rsp_valid,
  input logic [PU_IDX_W-1:0] rsp_pu
);

  int   fail_count = 0; // Read by the testbench at the end of the run
  logic read_cmd;

  assign read_cmd = cmd_valid && (cmd_op == OP_READ);

  // Fixed read latency, and no response without a read
  rsp_latency: assert property (@(posedge clk) disable iff (rst)
    rsp_valid == $past(read_cmd, 2))
    else begin
      $error("rsp_valid does not line up with a read command two cycles earlier");
      fail_count++;
    end

  rsp_reset: assert property (@(posedge clk) rst |=> !rsp_valid)
    else begin
      $error("rsp_valid is high after a reset cycle");
      fail_count++;
    end

  // Response carries the index of the unit that was read
  rsp_index: assert property (@(posedge clk) disable iff (rst)
    rsp_valid |-> rsp_pu == $past(cmd_pu, 2))
    else begin
      $error("rsp_pu does not match the unit of the read command");
      fail_count++;
    end

endmodule

bind pu_array_top pu_array_assertions i_pu_array_assertions (
  .clk       (clk),
  .rst       (rst),
  .cmd_valid (cmd_valid),
  .cmd_op    (cmd_op),
  .cmd_pu    (cmd_pu),
  .rsp_valid (rsp_valid),
  .rsp_pu    (rsp_pu)
);

/* tb_pu_array.sv */
`timescale 1ns/10ps

module tb_pu_array import pu_pkg::*; ();

  localparam int TIMEOUT = 20;

  logic                 clk;
  logic                 rst;
  logic                 cmd_valid;
  logic [PU_IDX_W-1:0]  cmd_pu;
  logic [PU_OP_W-1:0]   cmd_op;
  logic [PU_DATA_W-1:0] cmd_data;
  logic [PU_ATTR_W:0]   cmd_attr;
  logic                 rsp_valid;
  logic [PU_IDX_W-1:0]  rsp_pu;
  logic [PU_DATA_W-1:0] rsp_data;
  logic [PU_ATTR_W:0]   rsp_attr;

  // Reference model state, one entry per unit
  logic [PU_DATA_W-1:0] a_val    [PU_COUNT];
  logic                 a_inv    [PU_COUNT];
  logic                 sel_m    [PU_COUNT]; // Mirrors the unit's sel level
  logic [PU_DATA_W-1:0] exp_data [PU_COUNT];
  logic                 exp_inv  [PU_COUNT];
  logic [PU_IDX_W-1:0]  pend_pu  [$];       // Reads still in flight

  int seed;
  int errors;
  int checks;
  int test_num;
  int tests_failed;
  int mark;
  int assert_errs;

  pu_array_top i_pu_array_top (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd_pu    (cmd_pu),
    .cmd_op    (cmd_op),
    .cmd_data  (cmd_data),
    .cmd_attr  (cmd_attr),
    .rsp_valid (rsp_valid),
    .rsp_pu    (rsp_pu),
    .rsp_data  (rsp_data),
    .rsp_attr  (rsp_attr)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic fits_opnd(input logic [PU_DATA_W-1:0] x);
    return ($signed(x) >= -32768) && ($signed(x) <= 32767);
  endfunction

  function automatic logic [PU_DATA_W-1:0] ref_product(input logic [PU_DATA_W-1:0] a,
                                                       input logic [PU_DATA_W-1:0] b);
    logic signed [PU_DATA_W-1:0] sa;
    logic signed [PU_DATA_W-1:0] sb;
    sa = {{PU_OPND_W{a[PU_OPND_W-1]}}, a[PU_OPND_W-1:0]};
    sb = {{PU_OPND_W{b[PU_OPND_W-1]}}, b[PU_OPND_W-1:0]};
    return sa * sb;
  endfunction

  // Mostly 16-bit values, a quarter wide words
  function automatic logic [PU_DATA_W-1:0] random_opnd();
    logic [31:0] r;
    r = $random(seed);
    if (r[31:30] == 2'b11) begin
      return r;
    end
    return {{PU_OPND_W{r[15]}}, r[15:0]};
  endfunction

  // Response mismatches plus protocol assertion failures
  function automatic int total_errors();
    return errors + i_pu_array_top.i_pu_array_assertions.fail_count;
  endfunction

  task automatic send_cmd(input logic [PU_OP_W-1:0] op, input logic [PU_IDX_W-1:0] pu,
                          input logic [PU_DATA_W-1:0] data, input logic inv);
    logic [PU_ATTR_W:0] attr;
    attr = '0;
    attr[PU_INVALID_BIT] = inv;
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd_op    <= op;
    cmd_pu    <= pu;
    cmd_data  <= data;
    cmd_attr  <= attr;
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    cmd_valid <= 1'b0;
  endtask

  task automatic write_a(input logic [PU_IDX_W-1:0] pu, input logic [PU_DATA_W-1:0] data,
                         input logic inv);
    send_cmd(OP_WR_A, pu, data, inv);
    a_val[pu] = data;
    a_inv[pu] = inv;
    sel_m[pu] = 1'b1;
  endtask

  task automatic write_b(input logic [PU_IDX_W-1:0] pu, input logic [PU_DATA_W-1:0] data,
                         input logic inv);
    send_cmd(OP_WR_B, pu, data, inv);
    if (sel_m[pu]) begin // Falling sel latches a new product
      exp_data[pu] = ref_product(a_val[pu], data);
      exp_inv[pu]  = !fits_opnd(a_val[pu]) || !fits_opnd(data) || a_inv[pu] || inv;
    end
    sel_m[pu] = 1'b0;
    idle_cycle(); // Result readable two cycles after the write
  endtask

  task automatic write_pair(input logic [PU_IDX_W-1:0] pu, input logic [PU_DATA_W-1:0] a,
                            input logic [PU_DATA_W-1:0] b, input logic ainv, input logic binv);
    write_a(pu, a, ainv);
    write_b(pu, b, binv);
  endtask

  task automatic check_rsp(input logic [PU_IDX_W-1:0] pu);
    logic [PU_ATTR_W:0] ea;
    ea = '0;
    ea[PU_INVALID_BIT] = exp_inv[pu];
    checks++;
    assert (rsp_pu == pu) else begin
      $display("ERROR: rsp_pu got %h expected %h", rsp_pu, pu);
      errors++;
    end
    assert (rsp_data == exp_data[pu]) else begin
      $display("ERROR: rsp_data unit %0d got %h expected %h", pu, rsp_data, exp_data[pu]);
      errors++;
    end
    assert (rsp_attr == ea) else begin
      $display("ERROR: rsp_attr unit %0d got %h expected %h", pu, rsp_attr, ea);
      errors++;
    end
  endtask

  task automatic read_unit(input logic [PU_IDX_W-1:0] pu);
    int n;
    send_cmd(OP_READ, pu, '0, 1'b0);
    idle_cycle();
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!rsp_valid && n < TIMEOUT);
    if (rsp_valid) begin
      check_rsp(pu);
    end else begin
      $display("No response from unit %0d within %0d cycles", pu, TIMEOUT);
      errors++;
    end
  endtask

  // Back-to-back reads of random units, responses drained as they arrive
  task automatic read_many(input int count);
    logic [31:0]         r;
    logic [PU_IDX_W-1:0] pu;
    int                  n;
    for (int k = 0; k < count; k++) begin
      r = $random(seed);
      pu = r[PU_IDX_W-1:0];
      send_cmd(OP_READ, pu, '0, 1'b0);
      pend_pu.push_back(pu);
      @(negedge clk);
      if (rsp_valid) check_rsp(pend_pu.pop_front());
    end
    idle_cycle();
    n = 0;
    while (pend_pu.size() > 0 && n < TIMEOUT) begin
      @(negedge clk);
      if (rsp_valid) check_rsp(pend_pu.pop_front());
      n++;
    end
    if (pend_pu.size() > 0) begin
      $display("%0d responses missing after a read burst", pend_pu.size());
      errors++;
      pend_pu.delete();
    end
  endtask

  task automatic random_sweep(input int count);
    logic [31:0]          r;
    logic [PU_IDX_W-1:0]  pu;
    logic [PU_DATA_W-1:0] a;
    logic [PU_DATA_W-1:0] b;
    for (int k = 0; k < count; k++) begin
      r = $random(seed);
      pu = r[PU_IDX_W-1:0];
      a = random_opnd();
      b = random_opnd();
      write_pair(pu, a, b, r[8:4] == 5'd0, r[13:9] == 5'd0);
      read_many(4);
    end
  endtask

  task automatic finish_test(input string name);
    int now_errs;
    now_errs = total_errors();
    test_num++;
    if (now_errs == mark) begin
      $display("test %0d %s: PASS", test_num, name);
    end else begin
      $display("test %0d %s: FAIL with %0d errors", test_num, name, now_errs - mark);
      tests_failed++;
    end
    mark = now_errs;
  endtask

  initial begin
    rst       <= 1'b1;
    cmd_valid <= 1'b0;
    cmd_pu    <= '0;
    cmd_op    <= '0;
    cmd_data  <= '0;
    cmd_attr  <= '0;
    seed = 49418;
    errors = 0;
    checks = 0;
    test_num = 0;
    tests_failed = 0;
    mark = 0;
    for (int i = 0; i < PU_COUNT; i++) begin
      a_val[i]    = '0;
      a_inv[i]    = 1'b0;
      sel_m[i]    = 1'b0;
      exp_data[i] = '0;
      exp_inv[i]  = 1'b0;
    end
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    for (int i = 0; i < PU_COUNT; i++) read_unit(PU_IDX_W'(i));
    finish_test("reset state");

    write_pair(2'd0, 3, -7, 1'b0, 1'b0);
    write_pair(2'd1, -32768, -32768, 1'b0, 1'b0);
    write_pair(2'd2, 32767, -2, 1'b0, 1'b0);
    write_pair(2'd3, -1234, 5678, 1'b0, 1'b0);
    for (int i = 0; i < PU_COUNT; i++) read_unit(PU_IDX_W'(i));
    finish_test("signed products");

    write_pair(2'd1, 32'h0001_0005, 3, 1'b0, 1'b0);
    write_pair(2'd2, 32'h0000_8000, 2, 1'b0, 1'b0); // Operand sign bit without extension
    write_pair(2'd3, 5, 32'hFFFE_FFFF, 1'b0, 1'b0);
    for (int i = 1; i < PU_COUNT; i++) read_unit(PU_IDX_W'(i));
    finish_test("operand range");

    write_pair(2'd0, 100, -3, 1'b1, 1'b0);
    write_pair(2'd3, -9, 11, 1'b0, 1'b1);
    read_unit(2'd0);
    read_unit(2'd3);
    finish_test("input invalid flag");

    write_pair(2'd2, 12, -12, 1'b0, 1'b0);
    for (int i = 0; i < PU_COUNT; i++) read_unit(PU_IDX_W'(i));
    write_a(2'd1, 77, 1'b0);
    write_a(2'd1, -77, 1'b0);
    read_unit(2'd1);
    repeat (30) idle_cycle();
    for (int i = 0; i < PU_COUNT; i++) read_unit(PU_IDX_W'(i));
    finish_test("independence and persistence");

    random_sweep(24);
    finish_test("random sweep");

    assert_errs = i_pu_array_top.i_pu_array_assertions.fail_count;
    $display("Summary: %0d tests, %0d failing, %0d checks, %0d errors, %0d assertion errors",
             test_num, tests_failed, checks, errors, assert_errs);
    if (total_errors() == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* sources.f */
pu_pkg.sv
pu_mult.sv
pu_dispatch.sv
pu_collect.sv
pu_array_top.sv
pu_array_assertions.sv
tb_pu_array.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_pu_array \
  -Mdir obj_dir \
  -f sources.f
if [ $? -ne 0 ]; then
  echo "Verilator build did not complete"
  exit 1
fi

# Keep running past assertion errors so the testbench prints its summary
output=$(./obj_dir/Vtb_pu_array +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Test completed successfully"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
